//--- Bender.yml
package:
  name: array_heap

sources:
  - include_dirs:
      - design
    files:
      - design/arrayHeapPkg.sv
      - design/requestQueue.sv
      - design/heapDecode.sv
      - design/elementExecute.sv
      - design/arrayHeap.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/clockGen.sv
      - test/arrayHeapTb.sv

//--- design/arrayHeap.sv
/*
 * Top of the array heap. Requests enter a credit-backed queue, are
 * checked in decode and applied to storage in execute. Responses come
 * back in order, one per command, and are never back-pressured.
 */
`timescale 1ns/1ps

module arrayHeap (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       reqValid,
  input  arrayHeapPkg::heapRequestT  request,
  output logic                       creditReturn,
  output logic                       respValid,
  output arrayHeapPkg::heapResponseT response
);
  logic                      qValid;                // Queue to decode
  arrayHeapPkg::heapRequestT qRequest;
  logic                      execValid;             // Decode to execute
  arrayHeapPkg::heapExecT    exec;

  // ----------------------------------------------------------------------
  // Pipeline: queue, decode, execute
  // ----------------------------------------------------------------------
  requestQueue queue_i (
    .clock        (clock),
    .reset        (reset),
    .reqValid     (reqValid),
    .request      (request),
    .creditReturn (creditReturn),
    .qValid       (qValid),
    .qRequest     (qRequest)
  );

  heapDecode decode_i (
    .clock     (clock),
    .reset     (reset),
    .qValid    (qValid),
    .qRequest  (qRequest),
    .execValid (execValid),
    .exec      (exec)
  );

  elementExecute execute_i (
    .clock     (clock),
    .reset     (reset),
    .execValid (execValid),
    .exec      (exec),
    .respValid (respValid),
    .response  (response)
  );

endmodule

//--- design/arrayHeapPkg.sv
/*
 * Shared types of the array heap: opcodes, error codes, widths and the
 * structs passed between requester, queue, decode and execute.
 */
`include "arrayHeap_consts.svh"

package arrayHeapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayNumT;   // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] elemIndexT;  // Element within an array
  typedef logic [`HEAP_INDEX_BITS:0]   arraySizeT;  // 0 up to full
  typedef logic [`HEAP_DATA_BITS-1:0]  heapDataT;   // Element value

  typedef enum logic [3:0] {
    alloc    = 4'd0,                                // New or reused array
    free     = 4'd1,                                // Return array to free stack
    write    = 4'd2,                                // Store element, may grow size
    read     = 4'd3,                                // Load element
    size     = 4'd4,                                // Current element count
    push     = 4'd5,                                // Append at end
    pop      = 4'd6,                                // Remove from end
    add      = 4'd7,                                // Returns new value
    addAfter = 4'd8,                                // Returns old value
    subtract = 4'd9,                                // Returns new value
    subAfter = 4'd10,                               // Returns old value
    orOp     = 4'd11,
    xorOp    = 4'd12,
    andOp    = 4'd13,
    notOp    = 4'd14                                // Operand ignored
  } heapOpT;

  typedef enum logic [2:0] {
    none         = 3'd0,
    notAllocated = 3'd1,                            // Never handed out
    arrayFreed   = 3'd2,                            // Freed, also double free
    outOfBounds  = 3'd3,                            // Index at or past size
    arrayFull    = 3'd4,
    arrayEmpty   = 3'd5,
    outOfMemory  = 3'd6                             // No array left
  } heapErrorT;

  typedef struct packed {
    heapOpT    op;
    arrayNumT  array;
    elemIndexT index;
    heapDataT  data;
  } heapRequestT;

  typedef struct packed {
    arrayNumT  array;                               // Upper address bits
    elemIndexT index;                               // Lower address bits
  } heapAddrT;

  typedef struct packed {
    heapOpT    op;
    heapAddrT  addr;                                // Element to touch
    heapDataT  data;                                // Operand
    logic      access;                              // Touch storage
    heapDataT  direct;                              // Result when no access
    heapErrorT error;
  } heapExecT;

  typedef struct packed {
    heapDataT  data;
    heapErrorT error;
  } heapResponseT;

endpackage

//--- design/arrayHeap_consts.svh
/*
 * Dimensions of the array heap and its request queue.
 * Included by the package and by every module that sizes storage.
 */
`ifndef ARRAY_HEAP_CONSTS_SVH
`define ARRAY_HEAP_CONSTS_SVH

// ----------------------------------------------------------------------
// Heap geometry
// ----------------------------------------------------------------------
`define HEAP_ARRAY_BITS   3     // Bits in an array number, 8 arrays
`define HEAP_INDEX_BITS   2     // Bits in an element index, 4 elements
`define HEAP_DATA_BITS    12    // Element width

// ----------------------------------------------------------------------
// Request side flow control
// ----------------------------------------------------------------------
// The requester starts with this many credits after reset
`define HEAP_QUEUE_DEPTH  4     // Queue entries

`endif

//--- design/elementExecute.sv
/*
 * Execute stage: element storage plus a single-cycle read-modify-write
 * unit for the arithmetic and bitwise commands. Registers the response
 * one cycle after execValid.
 */
`timescale 1ns/1ps
`include "arrayHeap_consts.svh"

module elementExecute (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       execValid,
  input  arrayHeapPkg::heapExecT     exec,
  output logic                       respValid,
  output arrayHeapPkg::heapResponseT response
);
  localparam int Elements = 1 << (`HEAP_ARRAY_BITS + `HEAP_INDEX_BITS);

  arrayHeapPkg::heapDataT elements [Elements];      // Arrays in fixed blocks
  arrayHeapPkg::heapDataT oldValue;
  arrayHeapPkg::heapDataT newValue;                 // Written back
  arrayHeapPkg::heapDataT result;                   // Returned on access

  // ----------------------------------------------------------------------
  // Read-modify-write unit
  // ----------------------------------------------------------------------
  always_comb begin
    oldValue = elements[exec.addr];
    newValue = oldValue;                            // Read and pop keep it
    result   = oldValue;
    case (exec.op)
      arrayHeapPkg::write,
      arrayHeapPkg::push: begin
        newValue = exec.data;
        result   = exec.data;
      end
      arrayHeapPkg::add: begin
        newValue = oldValue + exec.data;            // Wraps at element width
        result   = newValue;
      end
      arrayHeapPkg::addAfter: newValue = oldValue + exec.data;
      arrayHeapPkg::subtract: begin
        newValue = oldValue - exec.data;
        result   = newValue;
      end
      arrayHeapPkg::subAfter: newValue = oldValue - exec.data;
      arrayHeapPkg::orOp: begin
        newValue = oldValue | exec.data;
        result   = newValue;
      end
      arrayHeapPkg::xorOp: begin
        newValue = oldValue ^ exec.data;
        result   = newValue;
      end
      arrayHeapPkg::andOp: begin
        newValue = oldValue & exec.data;
        result   = newValue;
      end
      arrayHeapPkg::notOp: begin
        newValue = ~oldValue;
        result   = newValue;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (execValid && exec.access) elements[exec.addr] <= newValue;
    if (execValid) begin
      response.data  <= exec.access ? result : exec.direct;  // Alloc, size, errors
      response.error <= exec.error;
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) respValid <= 1'b0;
    else        respValid <= execValid;
  end

  // Decode must never open storage for a failed command
  noAccessOnError: assert property (@(posedge clock) disable iff (!reset)
    execValid && exec.access |-> exec.error == arrayHeapPkg::none);

endmodule

//--- design/heapDecode.sv
/*
 * Decode stage: checks each command against allocation state and array
 * sizes, updates that state in the same cycle and resolves which element
 * the execute stage touches. Output is registered one cycle after qValid.
 */
`timescale 1ns/1ps
`include "arrayHeap_consts.svh"

module heapDecode (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      qValid,
  input  arrayHeapPkg::heapRequestT qRequest,
  output logic                      execValid,
  output arrayHeapPkg::heapExecT    exec
);
  localparam int Arrays = 1 << `HEAP_ARRAY_BITS;
  localparam int Length = 1 << `HEAP_INDEX_BITS;

  typedef logic [`HEAP_ARRAY_BITS:0] arrayCountT;   // 0 up to all arrays

  arrayHeapPkg::arraySizeT sizes [Arrays];          // Elements in each array
  logic [Arrays-1:0]       allocated;               // Live arrays
  arrayCountT              allocCount;              // Arrays ever handed out
  arrayCountT              freeTop;                 // Free stack depth
  arrayHeapPkg::arrayNumT  freeStack [Arrays];      // Freed array numbers

  arrayHeapPkg::arraySizeT curSize;
  arrayHeapPkg::arraySizeT reqSize;                 // Index widened to a size
  arrayHeapPkg::arrayNumT  topIndex;
  arrayHeapPkg::arrayNumT  allocTarget;
  arrayHeapPkg::heapErrorT error;
  arrayHeapPkg::heapExecT  nextExec;
  logic                    boundsOp;
  logic                    elementOp;
  logic                    update;

  // ----------------------------------------------------------------------
  // Checks and element resolution
  // ----------------------------------------------------------------------
  always_comb begin
    curSize     = sizes[qRequest.array];
    reqSize     = arrayHeapPkg::arraySizeT'(qRequest.index);
    topIndex    = arrayHeapPkg::arrayNumT'(freeTop - 1'b1);
    allocTarget = (freeTop != '0) ? freeStack[topIndex]         // Reuse latest free
                                  : arrayHeapPkg::arrayNumT'(allocCount);
    boundsOp    = qRequest.op inside {arrayHeapPkg::read, arrayHeapPkg::add,
                                      arrayHeapPkg::addAfter, arrayHeapPkg::subtract,
                                      arrayHeapPkg::subAfter, arrayHeapPkg::orOp,
                                      arrayHeapPkg::xorOp, arrayHeapPkg::andOp,
                                      arrayHeapPkg::notOp};
    elementOp   = boundsOp || qRequest.op inside {arrayHeapPkg::write,
                                                  arrayHeapPkg::push, arrayHeapPkg::pop};

    error = arrayHeapPkg::none;
    if (qRequest.op == arrayHeapPkg::alloc) begin
      if (freeTop == '0 && allocCount == arrayCountT'(Arrays)) begin
        error = arrayHeapPkg::outOfMemory;
      end
    end else if (arrayCountT'(qRequest.array) >= allocCount) begin
      error = arrayHeapPkg::notAllocated;
    end else if (!allocated[qRequest.array]) begin
      error = arrayHeapPkg::arrayFreed;             // Also a second free
    end else if (boundsOp && reqSize >= curSize) begin
      error = arrayHeapPkg::outOfBounds;
    end else if (qRequest.op == arrayHeapPkg::push &&
                 curSize == arrayHeapPkg::arraySizeT'(Length)) begin
      error = arrayHeapPkg::arrayFull;
    end else if (qRequest.op == arrayHeapPkg::pop && curSize == '0) begin
      error = arrayHeapPkg::arrayEmpty;
    end
    update = qValid && (error == arrayHeapPkg::none);

    nextExec.op         = qRequest.op;
    nextExec.addr.array = qRequest.array;
    nextExec.data       = qRequest.data;
    nextExec.error      = error;
    nextExec.access     = elementOp && (error == arrayHeapPkg::none);
    if (qRequest.op == arrayHeapPkg::push) begin
      nextExec.addr.index = arrayHeapPkg::elemIndexT'(curSize);          // Old size
    end else if (qRequest.op == arrayHeapPkg::pop) begin
      nextExec.addr.index = arrayHeapPkg::elemIndexT'(curSize - 1'b1);   // New size
    end else begin
      nextExec.addr.index = qRequest.index;
    end
    nextExec.direct = '0;                           // Free and errors return zero
    if (error == arrayHeapPkg::none) begin
      if (qRequest.op == arrayHeapPkg::alloc) begin
        nextExec.direct = arrayHeapPkg::heapDataT'(allocTarget);
      end else if (qRequest.op == arrayHeapPkg::size) begin
        nextExec.direct = arrayHeapPkg::heapDataT'(curSize);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Allocation state, visible to the very next command
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      execValid  <= 1'b0;
      allocated  <= '0;
      allocCount <= '0;
      freeTop    <= '0;
      for (int i = 0; i < Arrays; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      execValid <= qValid;
      if (update) begin
        case (qRequest.op)
          arrayHeapPkg::alloc: begin
            if (freeTop != '0) freeTop <= freeTop - 1'b1;    // Pop free stack
            else allocCount <= allocCount + 1'b1;            // Fresh array
            allocated[allocTarget] <= 1'b1;
            sizes[allocTarget]     <= '0;
          end
          arrayHeapPkg::free: begin
            freeTop                   <= freeTop + 1'b1;
            allocated[qRequest.array] <= 1'b0;
          end
          arrayHeapPkg::push: sizes[qRequest.array] <= curSize + 1'b1;
          arrayHeapPkg::pop:  sizes[qRequest.array] <= curSize - 1'b1;
          arrayHeapPkg::write: begin
            if (reqSize >= curSize) sizes[qRequest.array] <= reqSize + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (update && qRequest.op == arrayHeapPkg::free) begin
      freeStack[arrayHeapPkg::arrayNumT'(freeTop)] <= qRequest.array;
    end
    if (qValid) exec <= nextExec;
  end

  // Only arrays once handed out can sit on the free stack
  freeStackBound: assert property (@(posedge clock) disable iff (!reset)
    freeTop <= allocCount);

endmodule

//--- design/requestQueue.sv
/*
 * Credit-backed command FIFO in front of the decode stage.
 * Drains one entry per cycle into a registered output and hands
 * back one credit for every entry that leaves.
 */
`timescale 1ns/1ps
`include "arrayHeap_consts.svh"

module requestQueue (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      reqValid,
  input  arrayHeapPkg::heapRequestT request,
  output logic                      creditReturn,
  output logic                      qValid,
  output arrayHeapPkg::heapRequestT qRequest
);
  localparam int Depth   = `HEAP_QUEUE_DEPTH;
  localparam int PtrBits = $clog2(Depth);

  arrayHeapPkg::heapRequestT entries [Depth];       // Queue storage
  logic [PtrBits-1:0]        writePtr;
  logic [PtrBits-1:0]        readPtr;
  logic [PtrBits:0]          count;                 // Entries held
  logic                      dequeue;
  logic                      full;

  assign dequeue      = (count != '0);              // Decode never stalls
  assign full         = (count == (PtrBits + 1)'(Depth));
  assign creditReturn = qValid;                     // One credit per entry out

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      writePtr <= '0;
      readPtr  <= '0;
      count    <= '0;
      qValid   <= 1'b0;
    end else begin
      if (reqValid) writePtr <= writePtr + 1'b1;    // Wraps at power of two depth
      if (dequeue)  readPtr  <= readPtr + 1'b1;
      count  <= count + reqValid - dequeue;
      qValid <= dequeue;                            // Entry moved to output
    end
  end

  always_ff @(posedge clock) begin
    if (reqValid) entries[writePtr] <= request;
    if (dequeue)  qRequest <= entries[readPtr];     // Output register
  end

  // Requester must hold a credit, so it never finds the queue full
  creditOverrun: assert property (@(posedge clock) disable iff (!reset)
    reqValid |-> !full);

endmodule

//--- sim.f
+incdir+design
design/arrayHeapPkg.sv
design/requestQueue.sv
design/heapDecode.sv
design/elementExecute.sv
design/arrayHeap.sv
test/clockGen.sv
test/arrayHeapTb.sv

//--- test/arrayHeapTb.sv
/*
 * Testbench for the array heap. Commands and expected responses come
 * from test/heap_tests.txt. Requests go out on the falling edge under
 * credit control and every response is checked in request order.
 */
`timescale 1ns/1ps
`include "arrayHeap_consts.svh"

module arrayHeapTb;
  localparam int Depth         = `HEAP_QUEUE_DEPTH; // Starting credits
  localparam int ClockPeriod   = 100;
  localparam int ResetCycles   = 3;
  localparam int CyclesPerTest = 20;                // Watchdog budget per line
  localparam int BurstLines    = 8;                 // File tail, sent without gaps

  logic                       clock;
  logic                       reset;
  logic                       reqValid;
  arrayHeapPkg::heapRequestT  request;
  logic                       creditReturn;
  logic                       respValid;
  arrayHeapPkg::heapResponseT response;

  arrayHeapPkg::heapRequestT  testRequests [$];
  arrayHeapPkg::heapResponseT testResponses [$];    // Expected, in order
  int                         numTests;
  logic                       loaded;
  int                         credits;              // Changes on falling edges only
  int                         matched;
  logic [31:0]                randState;

  clockGen #(.HalfPeriod(ClockPeriod / 2)) clock_i (.clock(clock));

  arrayHeap dut_i (
    .clock        (clock),
    .reset        (reset),
    .reqValid     (reqValid),
    .request      (request),
    .creditReturn (creditReturn),
    .respValid    (respValid),
    .response     (response)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic stopOnFailure(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic checkData(input int testNo, input arrayHeapPkg::heapDataT want,
                           input arrayHeapPkg::heapDataT got);
    if (got !== want) begin                         // X counts as a mismatch
      stopOnFailure($sformatf("error at %0t: test %0d data is %h, expected %h",
                              $time, testNo, got, want));
    end
  endtask

  task automatic checkError(input int testNo, input arrayHeapPkg::heapErrorT want,
                            input arrayHeapPkg::heapErrorT got);
    if (got !== want) begin
      stopOnFailure($sformatf("error at %0t: test %0d error is %s, expected %s",
                              $time, testNo, got.name(), want.name()));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Lines that do not parse as six hex fields are comments
  task automatic loadTests();
    int                         fd;
    int                         status;
    int                         fields;
    logic [8*128-1:0]           lineBuf;
    logic [31:0]                op, arr, idx, data, wantData, wantError;
    arrayHeapPkg::heapRequestT  req;
    arrayHeapPkg::heapResponseT resp;
    fd = $fopen("test/heap_tests.txt", "r");
    if (fd == 0) stopOnFailure("could not open test/heap_tests.txt for reading");
    while (!$feof(fd)) begin
      lineBuf = '0;
      status  = $fgets(lineBuf, fd);
      fields  = 0;
      if (status > 0) begin
        fields = $sscanf(lineBuf, "%h %h %h %h %h %h", op, arr, idx, data, wantData, wantError);
      end
      if (fields == 6) begin
        req.op     = arrayHeapPkg::heapOpT'(op[3:0]);
        req.array  = arrayHeapPkg::arrayNumT'(arr);
        req.index  = arrayHeapPkg::elemIndexT'(idx);
        req.data   = arrayHeapPkg::heapDataT'(data);
        resp.data  = arrayHeapPkg::heapDataT'(wantData);
        resp.error = arrayHeapPkg::heapErrorT'(wantError[2:0]);
        testRequests.push_back(req);
        testResponses.push_back(resp);
      end
    end
    $fclose(fd);
    numTests = testRequests.size();
    if (numTests == 0) stopOnFailure("the test file holds no commands");
  endtask

  // ----------------------------------------------------------------------
  // Requester with credit counter
  // ----------------------------------------------------------------------
  initial begin : driveRequests
    int sent;
    int idle;                                       // Gap cycles still to wait
    reset     = 1'b0;                               // Held for ResetCycles
    reqValid  = 1'b0;
    request   = '0;
    credits   = Depth;
    loaded    = 1'b0;
    randState = 32'hf54c63f8;
    loadTests();
    loaded = 1'b1;
    repeat (ResetCycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    sent  = 0;
    idle  = 0;
    while (sent < numTests || credits < Depth) begin
      @(negedge clock);
      if (creditReturn) credits++;                  // One credit per dequeue
      if (credits > Depth) stopOnFailure("more credits came back than requests were sent");
      reqValid = 1'b0;
      if (sent < numTests && idle > 0) begin
        idle--;
      end else if (sent < numTests && credits > 0) begin
        request  = testRequests[sent];
        reqValid = 1'b1;                            // Taken at next rising edge
        credits--;
        sent++;
        randState = xorshift(randState);
        idle = (sent >= numTests - BurstLines) ? 0 : int'(randState[1:0]);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Response monitor and end of run
  // ----------------------------------------------------------------------
  initial begin : checkResponses
    wait (loaded);
    matched = 0;
    while (matched < numTests) begin
      @(negedge clock);                             // Response stable mid cycle
      if (respValid) begin
        checkData(matched + 1, testResponses[matched].data, response.data);
        checkError(matched + 1, testResponses[matched].error, response.error);
        matched++;
      end
    end
    repeat (2) @(posedge clock);
    if (credits == Depth) begin                     // Every credit home again
      $display("Regression passed");
      $finish;
    end else begin
      stopOnFailure($sformatf("only %0d of %0d credits came back", credits, Depth));
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (ResetCycles + numTests * CyclesPerTest) @(posedge clock);
    stopOnFailure($sformatf("timed out with %0d of %0d responses still missing",
                            numTests - matched, numTests));
  end

endmodule

//--- test/clockGen.sv
/*
 * Free running testbench clock, low at time zero.
 * The default half period gives a 100 ns cycle.
 */
`timescale 1ns/1ps

module clockGen #(
  parameter int HalfPeriod = 50                     // In ns
) (
  output logic clock
);
  initial begin
    clock = 1'b0;                                   // First rising edge at 50 ns
    forever #(HalfPeriod) clock = ~clock;
  end

endmodule

//--- test/heap_tests.txt
// Columns, all hex: op array index data expectedData expectedError
// Ops 0 alloc 1 free 2 write 3 read 4 size 5 push 6 pop 7 add 8 addAfter 9 subtract
// a subAfter b or c xor d and e not; errors 0 none 1 notAllocated 2 freed 3 bounds 4 full 5 empty 6 oom
3 0 0 000 000 1
0 0 0 000 000 0
0 0 0 000 001 0
0 0 0 000 002 0
5 0 0 001 001 0
5 0 0 002 002 0
4 0 0 000 002 0
6 0 0 000 002 0
6 0 0 000 001 0
6 0 0 000 000 5
5 0 0 00a 00a 0
5 0 0 00b 00b 0
5 0 0 00c 00c 0
5 0 0 00d 00d 0
5 0 0 00e 000 4
4 0 0 000 004 0
2 1 2 5a5 5a5 0
4 1 0 000 003 0
3 1 2 000 5a5 0
3 1 3 000 000 3
7 1 2 a5c 001 0
8 1 2 010 001 0
9 1 2 012 fff 0
a 1 2 0ff fff 0
b 1 2 0f0 ff0 0
c 1 2 3c3 c33 0
d 1 2 0f6 032 0
e 1 2 000 fcd 0
3 1 2 000 fcd 0
1 2 0 000 000 0
3 2 0 000 000 2
1 2 0 000 000 2
1 1 0 000 000 0
0 0 0 000 001 0
0 0 0 000 002 0
0 0 0 000 003 0
0 0 0 000 004 0
0 0 0 000 005 0
0 0 0 000 006 0
0 0 0 000 007 0
0 0 0 000 000 6
5 3 0 123 123 0
2 3 3 789 789 0
4 3 0 000 004 0
3 3 0 000 123 0
7 3 0 001 124 0
6 3 0 000 789 0
3 3 3 000 000 3
3 7 0 000 000 3
